//--- logic/dfp_bus_pkg.sv
// Debug front panel bus widths, I/O command map and decoded operations
`default_nettype none

package dfp_bus_pkg;

   localparam int DATA_W = 16;                  // Backplane data bus
   localparam int ADDR_W = 10;                  // Kept I/O address bits

   //////////////////////////////////////////////////
   // Command addresses within page 1xx
   //////////////////////////////////////////////////
   localparam logic [7:0] CMD_OUTREG   = 8'h00; // Output register
   localparam logic [7:0] CMD_ENEF     = 8'h08;
   localparam logic [7:0] CMD_DISEF    = 8'h09;
   localparam logic [7:0] CMD_SENTINEL = 8'h0f; // Should never be reached
   localparam logic [7:0] CMD_PRINTA   = 8'h10;
   localparam logic [7:0] CMD_PRINTC   = 8'h11;
   localparam logic [7:0] CMD_PRINTD   = 8'h12; // Signed decimal
   localparam logic [7:0] CMD_PRINTU   = 8'h13;
   localparam logic [7:0] CMD_PRINTH   = 8'h14;
   localparam logic [7:0] CMD_PRINTB   = 8'h15;
   localparam logic [7:0] CMD_PRINTSP  = 8'h16;
   localparam logic [7:0] CMD_PRINTNL  = 8'h17;
   localparam logic [7:0] CMD_DEBUGON  = 8'h18;
   localparam logic [7:0] CMD_DEBUGOFF = 8'h19;
   localparam logic [7:0] CMD_DUMP     = 8'h1a;
   localparam logic [7:0] CMD_PRINTHI  = 8'h1b; // High half of a long
   localparam logic [7:0] CMD_PRINTLO  = 8'h1c; // Low half, triggers the print
   localparam logic [7:0] CMD_HALT     = 8'h1d;
   localparam logic [7:0] CMD_SUCCESS  = 8'h1e;
   localparam logic [7:0] CMD_FAIL     = 8'h1f;

   // What execute has to do with a command
   typedef enum logic [2:0] {
      OP_OUTREG,
      OP_PRINT,
      OP_PRINTHI,
      OP_PRINTLO,
      OP_HALT,
      OP_REPORT,                                // Report only, no side effect
      OP_FAULT                                  // Sentinel or unknown address
   } dfp_op_t;

endpackage

`default_nettype wire

//--- logic/dfp_report_pkg.sv
// Debug front panel report codes, payload formats and payload layout
`default_nettype none

package dfp_report_pkg;

   //////////////////////////////////////////////////
   // Three-digit report codes
   //////////////////////////////////////////////////
   // Same numbering as the hardware panel firmware, so
   // test scripts can read both
   localparam logic [9:0] RPT_OUTREG   = 10'd321;
   localparam logic [9:0] RPT_PRINT    = 10'd340;
   localparam logic [9:0] RPT_SENTINEL = 10'd341;
   localparam logic [9:0] RPT_HALTED   = 10'd305;
   localparam logic [9:0] RPT_SUCCESS  = 10'd345;
   localparam logic [9:0] RPT_FAIL     = 10'd346;
   localparam logic [9:0] RPT_UNIMPL   = 10'd509; // Unimplemented command

   // How the consumer should render the payload
   typedef enum logic [2:0] {
      FMT_NONE,                                   // No payload shown
      FMT_HEX,
      FMT_CHAR,
      FMT_SDEC,                                   // Signed decimal
      FMT_UDEC,
      FMT_BIN,
      FMT_LONG                                    // 32-bit hex, both halves
   } rpt_fmt_t;

   //////////////////////////////////////////////////
   // Report payload
   //////////////////////////////////////////////////
   typedef struct packed {
      logic [15:0] hi;                            // Latched by PRINTHI
      logic [15:0] lo;                            // Bus word
   } rpt_halves_t;

   // Single values read as long_val, PRINTLO builds halves
   typedef union packed {
      logic [31:0] long_val;
      rpt_halves_t halves;
   } rpt_data_u;

endpackage

`default_nettype wire

//--- logic/dfp_cmd_if.sv
// Decoded debug command passed from the decode stage to the execute stage
`default_nettype none

interface dfp_cmd_if import dfp_bus_pkg::*, dfp_report_pkg::*; ();

   logic       valid;     // One-cycle strobe per command
   dfp_op_t    op;        // What execute does with it
   logic [9:0] code;      // Report code to emit
   rpt_fmt_t   fmt;
   rpt_data_u  payload;   // Bus word or address, already extended

   // Decode side
   modport producer (
      output valid, op, code, fmt, payload
   );

   // Execute side, no ready back
   modport consumer (
      input valid, op, code, fmt, payload
   );

endinterface

`default_nettype wire

//--- logic/dfp_bus_capture.sv
// Pipeline stage 1, registers a qualified write to I/O page 1xx
`default_nettype none

module dfp_bus_capture import dfp_bus_pkg::*; (
   input  wire logic              nw,          // Write strobe, rising edge
   input  wire logic              rst,
   input  wire logic              niodev1xx,   // Page 1xx select, active low
   input  wire logic [23:0]       ab,
   input  wire logic [15:0]       db,
   output logic                   cap_valid,
   output logic [ADDR_W-1:0]      cap_addr,
   output logic [DATA_W-1:0]      cap_data
);

   //////////////////////////////////////////////////
   // Write qualifier
   //////////////////////////////////////////////////
   // Every nw edge is a write, the select says whether it is ours
   always_ff @(posedge nw) begin
      if (rst) begin
         cap_valid <= 1'b0;
      end else begin
         cap_valid <= ~niodev1xx;
      end
   end

   //////////////////////////////////////////////////
   // Address and data
   //////////////////////////////////////////////////
   // Only loaded on our own writes, held otherwise
   always_ff @(posedge nw) begin
      if (!niodev1xx) begin
         cap_addr <= ab[ADDR_W-1:0];     // Page bits decoded on the bus board
         cap_data <= db;
      end
   end

endmodule

`default_nettype wire

//--- logic/dfp_cmd_decode.sv
// Pipeline stage 2, turns a page address into an operation and a report record
`default_nettype none

module dfp_cmd_decode import dfp_bus_pkg::*, dfp_report_pkg::*; (
   input  wire logic              nw,
   input  wire logic              rst,
   input  wire logic              cap_valid,
   input  wire logic [ADDR_W-1:0] cap_addr,
   input  wire logic [DATA_W-1:0] cap_data,
   dfp_cmd_if.producer            cmd
);

   dfp_op_t     op_d;
   logic [9:0]  code_d;
   rpt_fmt_t    fmt_d;
   rpt_data_u   payload_d;
   logic [31:0] word_zx;     // Bus word, zero-extended
   logic [31:0] word_sx;     // Bus word, sign-extended
   logic [31:0] addr_zx;     // Full kept address for 509 reports

   assign word_zx = {{(32 - DATA_W){1'b0}}, cap_data};
   assign word_sx = {{(32 - DATA_W){cap_data[DATA_W-1]}}, cap_data};
   assign addr_zx = {{(32 - ADDR_W){1'b0}}, cap_addr};

   //////////////////////////////////////////////////
   // Address map
   //////////////////////////////////////////////////
   always_comb begin
      op_d               = OP_PRINT;        // Most of the page prints
      code_d             = RPT_PRINT;
      fmt_d              = FMT_NONE;
      payload_d.long_val = word_zx;
      case (cap_addr[7:0])                  // Bits 9:8 ignored, as on the board
         CMD_OUTREG: begin
            op_d   = OP_OUTREG;
            code_d = RPT_OUTREG;
            fmt_d  = FMT_HEX;
         end
         CMD_PRINTA, CMD_PRINTH: fmt_d = FMT_HEX;
         CMD_PRINTC:             fmt_d = FMT_CHAR;
         CMD_PRINTD: begin
            fmt_d              = FMT_SDEC;
            payload_d.long_val = word_sx;
         end
         CMD_PRINTU:             fmt_d = FMT_UDEC;
         CMD_PRINTB:             fmt_d = FMT_BIN;
         CMD_PRINTSP: begin
            fmt_d              = FMT_CHAR;
            payload_d.long_val = 32'd32;    // Space
         end
         CMD_PRINTNL: begin
            fmt_d              = FMT_CHAR;
            payload_d.long_val = 32'd10;    // Line feed
         end
         CMD_PRINTHI:            op_d = OP_PRINTHI;
         CMD_PRINTLO: begin
            op_d  = OP_PRINTLO;             // High half added in execute
            fmt_d = FMT_LONG;
         end
         CMD_ENEF, CMD_DISEF, CMD_DEBUGON, CMD_DEBUGOFF, CMD_DUMP: begin
            op_d               = OP_REPORT;
            code_d             = RPT_UNIMPL;
            payload_d.long_val = addr_zx;
         end
         CMD_HALT, CMD_SUCCESS, CMD_FAIL: begin
            op_d               = (cap_addr[7:0] == CMD_HALT) ? OP_HALT : OP_REPORT;
            code_d             = (cap_addr[7:0] == CMD_HALT)    ? RPT_HALTED :
                                 (cap_addr[7:0] == CMD_SUCCESS) ? RPT_SUCCESS : RPT_FAIL;
            payload_d.long_val = '0;
         end
         CMD_SENTINEL: begin
            op_d               = OP_FAULT;
            code_d             = RPT_SENTINEL;
            payload_d.long_val = '0;
         end
         default: begin                     // Hole in the map
            op_d               = OP_FAULT;
            code_d             = RPT_UNIMPL;
            payload_d.long_val = addr_zx;
         end
      endcase
   end

   //////////////////////////////////////////////////
   // Stage register
   //////////////////////////////////////////////////
   always_ff @(posedge nw) begin
      if (rst) begin
         cmd.valid <= 1'b0;
      end else begin
         cmd.valid <= cap_valid;
      end
   end

   always_ff @(posedge nw) begin
      cmd.op      <= op_d;
      cmd.code    <= code_d;
      cmd.fmt     <= fmt_d;
      cmd.payload <= payload_d;
   end

endmodule

`default_nettype wire

//--- logic/dfp_exec.sv
// Pipeline stage 3, applies side effects and emits one report pulse per command
`default_nettype none

module dfp_exec import dfp_bus_pkg::*, dfp_report_pkg::*; (
   input  wire logic         nw,
   input  wire logic         rst,
   dfp_cmd_if.consumer       cmd,
   output logic [DATA_W-1:0] out_reg,        // The panel output register
   output logic              nhalt,          // Processor halt, active low
   output logic              fault,          // Pulses with sentinel or unknown
   output logic              report_valid,
   output logic [9:0]        report_code,
   output rpt_fmt_t          report_fmt,
   output rpt_data_u         report_data
);

   logic [DATA_W-1:0] hi_latch;              // PRINTHI word waiting for PRINTLO
   logic              accept;                // Command taken this edge
   logic              emits;                 // Command produces a report
   rpt_data_u         data_d;

   // A halted panel ignores everything, in-flight commands too
   assign accept = cmd.valid & nhalt;
   assign emits  = accept & (cmd.op != OP_PRINTHI);

   //////////////////////////////////////////////////
   // Payload assembly
   //////////////////////////////////////////////////
   always_comb begin
      data_d = cmd.payload;                  // Already extended by decode
      if (cmd.op == OP_PRINTLO) begin
         data_d.halves.hi = hi_latch;        // Low half is the bus word
      end
   end

   //////////////////////////////////////////////////
   // Control state
   //////////////////////////////////////////////////
   always_ff @(posedge nw) begin
      if (rst) begin
         out_reg      <= '0;
         nhalt        <= 1'b1;
         fault        <= 1'b0;
         report_valid <= 1'b0;
      end else begin
         report_valid <= emits;              // Single-cycle pulse
         fault        <= accept & (cmd.op == OP_FAULT);
         if (accept) begin
            case (cmd.op)
               OP_OUTREG: out_reg <= cmd.payload.halves.lo;
               OP_HALT:   nhalt   <= 1'b0;   // Stays low until reset
               default:   ;                  // Report only
            endcase
         end
      end
   end

   //////////////////////////////////////////////////
   // Report record and long latch
   //////////////////////////////////////////////////
   always_ff @(posedge nw) begin
      if (emits) begin
         report_code <= cmd.code;
         report_fmt  <= cmd.fmt;
         report_data <= data_d;
      end
      if (accept && cmd.op == OP_PRINTHI) begin
         hi_latch <= cmd.payload.halves.lo;  // Silent, no report
      end
   end

endmodule

`default_nettype wire

//--- logic/dfp_top.sv
// Debug front panel top level, capture then decode then execute on the nw strobe
`default_nettype none

module dfp_top import dfp_bus_pkg::*, dfp_report_pkg::*; (
   input  wire logic         nw,             // Bus write strobe, used as clock
   input  wire logic         rst,
   input  wire logic         niodev1xx,
   input  wire logic [23:0]  ab,
   input  wire logic [15:0]  db,
   output logic [DATA_W-1:0] out_reg,
   output logic              nhalt,
   output logic              fault,
   output logic              report_valid,
   output logic [9:0]        report_code,
   output rpt_fmt_t          report_fmt,
   output rpt_data_u         report_data
);

   // Stage 1 to stage 2
   logic              cap_valid;
   logic [ADDR_W-1:0] cap_addr;
   logic [DATA_W-1:0] cap_data;

   dfp_cmd_if cmd_bus ();                    // Stage 2 to stage 3

   dfp_bus_capture u_capture (
      .nw        (nw),
      .rst       (rst),
      .niodev1xx (niodev1xx),
      .ab        (ab),
      .db        (db),
      .cap_valid (cap_valid),
      .cap_addr  (cap_addr),
      .cap_data  (cap_data)
   );

   dfp_cmd_decode u_decode (
      .nw        (nw),
      .rst       (rst),
      .cap_valid (cap_valid),
      .cap_addr  (cap_addr),
      .cap_data  (cap_data),
      .cmd       (cmd_bus.producer)
   );

   dfp_exec u_exec (
      .nw           (nw),
      .rst          (rst),
      .cmd          (cmd_bus.consumer),
      .out_reg      (out_reg),
      .nhalt        (nhalt),
      .fault        (fault),
      .report_valid (report_valid),
      .report_code  (report_code),
      .report_fmt   (report_fmt),
      .report_data  (report_data)
   );

endmodule

`default_nettype wire

//--- tests/dfp_properties.sv
// Debug front panel protocol assertions on halt, fault and report pulses
`default_nettype none

module dfp_properties import dfp_report_pkg::*; (
   input wire logic       nw,
   input wire logic       rst,
   input wire logic       nhalt,
   input wire logic       fault,
   input wire logic       report_valid,
   input wire logic [9:0] report_code
);
   timeunit 1ns;
   timeprecision 1ps;

   int assert_errs = 0;                       // Failed assertion count

   //////////////////////////////////////////////////
   // Halt and fault rules
   //////////////////////////////////////////////////
   halt_sticky: assert property (@(posedge nw) disable iff (rst) !nhalt |=> !nhalt)
      else begin
         assert_errs++;
         $error("nhalt rose again without a reset");
      end

   // Only sentinel and unknown addresses fault
   fault_with_report: assert property (@(posedge nw) disable iff (rst)
      fault |-> report_valid && (report_code == RPT_SENTINEL || report_code == RPT_UNIMPL))
      else begin
         assert_errs++;
         $error("fault without a 341 or 509 report");
      end

   reset_quiet: assert property (@(posedge nw) rst |=> !report_valid && !fault)
      else begin
         assert_errs++;
         $error("report_valid or fault high right after reset");
      end

endmodule

bind dfp_top dfp_properties u_props (
   .nw           (nw),
   .rst          (rst),
   .nhalt        (nhalt),
   .fault        (fault),
   .report_valid (report_valid),
   .report_code  (report_code)
);

`default_nettype wire

//--- tests/dfp_tb.sv
// Debug front panel testbench, seeded random command stream checked against a reference model
`default_nettype none

module dfp_tb import dfp_bus_pkg::*, dfp_report_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   typedef struct {
      logic [9:0]        code;
      rpt_fmt_t          fmt;
      rpt_data_u         data;
      logic [DATA_W-1:0] out;                 // out_reg once the command is done
      logic              flt;                 // Fault expected with the report
   } exp_rec_t;

   logic              nw, rst, niodev1xx;
   logic [23:0]       ab;
   logic [15:0]       db;
   logic [DATA_W-1:0] out_reg;
   logic              nhalt, fault, report_valid;
   logic [9:0]        report_code;
   rpt_fmt_t          report_fmt;
   rpt_data_u         report_data;

   exp_rec_t          exp_q[$];               // Reports still owed by the DUT
   logic [DATA_W-1:0] m_out, m_hi;            // Model output register and long latch
   bit                m_halted;
   int                val_errs, proto_errs, wait_errs;
   // Every command except HALT, which only the directed test uses
   logic [7:0] cmd_list[$] = '{CMD_OUTREG, CMD_ENEF, CMD_DISEF, CMD_SENTINEL, CMD_PRINTA,
      CMD_PRINTC, CMD_PRINTD, CMD_PRINTU, CMD_PRINTH, CMD_PRINTB, CMD_PRINTSP, CMD_PRINTNL,
      CMD_DEBUGON, CMD_DEBUGOFF, CMD_DUMP, CMD_PRINTHI, CMD_PRINTLO, CMD_SUCCESS, CMD_FAIL};

   dfp_top u_dfp_top (.*);

   initial begin
      nw = 1'b0;
      forever #10 nw = ~nw;                   // 20 ns period
   end

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////
   task automatic check_report(input logic [9:0] code, exp_code, input rpt_fmt_t fmt, exp_fmt,
                               input rpt_data_u data, exp_data);
      if (code !== exp_code) begin
         $display("ERR report_code got %h exp %h", code, exp_code);
         val_errs++;
      end
      if (fmt !== exp_fmt) begin
         $display("ERR report_fmt got %h exp %h", fmt, exp_fmt);
         val_errs++;
      end
      if (data !== exp_data) begin
         $display("ERR report_data got %h exp %h", data, exp_data);
         val_errs++;
      end
   endtask

   task automatic check_word(input string name, input logic [DATA_W-1:0] got, exp);
      if (got !== exp) begin
         $display("ERR %s got %h exp %h", name, got, exp);
         val_errs++;
      end
   endtask

   task automatic check_level(input string name, input logic got, exp);
      if (got !== exp) begin
         $display("ERR %s got %h exp %h", name, got, exp);
         val_errs++;
      end
   endtask

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////
   function automatic void model_write(input logic [9:0] addr, input logic [15:0] data);
      exp_rec_t r;
      bit       emit;
      if (m_halted) return;                   // Panel stopped, command lost
      emit            = 1'b1;
      r.flt           = 1'b0;
      r.code          = RPT_PRINT;
      r.fmt           = FMT_NONE;
      r.data.long_val = {16'h0000, data};
      case (addr[7:0])                        // Page byte selects the command
         CMD_OUTREG: begin
            m_out  = data;
            r.code = RPT_OUTREG;
            r.fmt  = FMT_HEX;
         end
         CMD_PRINTA, CMD_PRINTH: r.fmt = FMT_HEX;
         CMD_PRINTC:  r.fmt = FMT_CHAR;
         CMD_PRINTD: begin
            r.fmt           = FMT_SDEC;
            r.data.long_val = {{16{data[15]}}, data};
         end
         CMD_PRINTU:  r.fmt = FMT_UDEC;
         CMD_PRINTB:  r.fmt = FMT_BIN;
         CMD_PRINTSP: begin
            r.fmt           = FMT_CHAR;
            r.data.long_val = 32'd32;
         end
         CMD_PRINTNL: begin
            r.fmt           = FMT_CHAR;
            r.data.long_val = 32'd10;
         end
         CMD_PRINTHI: begin
            m_hi = data;                      // Silent
            emit = 1'b0;
         end
         CMD_PRINTLO: begin
            r.fmt             = FMT_LONG;
            r.data.halves.hi  = m_hi;
            r.data.halves.lo  = data;
         end
         CMD_ENEF, CMD_DISEF, CMD_DEBUGON, CMD_DEBUGOFF, CMD_DUMP: begin
            r.code          = RPT_UNIMPL;
            r.data.long_val = {22'h0, addr};
         end
         CMD_HALT: begin
            r.code          = RPT_HALTED;
            r.data.long_val = 32'h0;
            m_halted        = 1'b1;
         end
         CMD_SUCCESS: begin
            r.code          = RPT_SUCCESS;
            r.data.long_val = 32'h0;
         end
         CMD_FAIL: begin
            r.code          = RPT_FAIL;
            r.data.long_val = 32'h0;
         end
         CMD_SENTINEL: begin
            r.code          = RPT_SENTINEL;
            r.data.long_val = 32'h0;
            r.flt           = 1'b1;
         end
         default: begin
            r.code          = RPT_UNIMPL;
            r.data.long_val = {22'h0, addr};
            r.flt           = 1'b1;
         end
      endcase
      r.out = m_out;
      if (emit) exp_q.push_back(r);
   endfunction

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////
   task automatic bus_write(input logic [9:0] addr, input logic [15:0] data, input logic sel);
      @(negedge nw);
      niodev1xx = ~sel;
      ab        = {14'($urandom()), addr};    // Page bits are noise to the panel
      db        = data;
      if (sel) model_write(addr, data);
   endtask

   task automatic apply_reset();
      @(negedge nw);
      rst       = 1'b1;
      niodev1xx = 1'b1;
      repeat (5) @(negedge nw);
      rst       = 1'b0;
      m_out     = '0;
      m_halted  = 1'b0;
   endtask

   task automatic drain();
      int n;
      @(negedge nw);
      niodev1xx = 1'b1;
      n = 0;
      while (exp_q.size() != 0 && n < 50) begin
         @(posedge nw);
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("Timed out with %0d expected reports never seen", exp_q.size());
         wait_errs++;
         exp_q.delete();
      end
      repeat (3) @(negedge nw);               // Room for stray pulses
   endtask

   // Outputs settled half a cycle after the nw edge
   always @(negedge nw) begin : monitor
      exp_rec_t e;
      if (!rst && report_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            $display("Report pulse with code %0d when none was expected", report_code);
            proto_errs++;
         end else begin
            e = exp_q.pop_front();
            check_report(report_code, e.code, report_fmt, e.fmt, report_data, e.data);
            check_word("out_reg", out_reg, e.out);
            check_level("fault", fault, e.flt);
         end
      end else if (!rst && fault === 1'b1) begin
         $display("Fault pulsed without a report");
         proto_errs++;
      end
   end

   initial begin : main
      logic [9:0] addr;
      int         total;
      rst        = 1'b1;
      niodev1xx  = 1'b1;
      ab         = '0;
      db         = '0;
      m_hi       = '0;
      void'($urandom(32'hdd32_927f));
      apply_reset();
      bus_write(CMD_OUTREG, 16'hbeef, 1'b1);
      bus_write(CMD_OUTREG, 16'h1234, 1'b0);  // Not our page
      drain();
      check_word("out_reg", out_reg, m_out);
      for (int i = 8'h10; i <= 8'h17; i++) bus_write(10'(i), 16'h8041 + 16'(i), 1'b1);
      bus_write(CMD_PRINTHI, 16'hcafe, 1'b1);
      bus_write(CMD_PRINTA, 16'h0001, 1'b1);
      bus_write(CMD_PRINTLO, 16'hf00d, 1'b1);
      foreach (cmd_list[i]) bus_write({2'b01, cmd_list[i]}, 16'h7f00 | 16'(i), 1'b1);
      bus_write(10'h2e5, 16'h0, 1'b1);        // Hole in the map
      drain();
      repeat (2000) begin                     // Writes on most cycles
         if ($urandom_range(0, 99) < 10) addr = 10'($urandom());
         else addr = {2'($urandom()), cmd_list[$urandom_range(0, cmd_list.size() - 1)]};
         if (addr[7:0] == CMD_HALT) addr[7:0] = CMD_SUCCESS;
         bus_write(addr, 16'($urandom()), $urandom_range(0, 99) < 85);
      end
      drain();
      bus_write(CMD_OUTREG, 16'h5a5a, 1'b1);
      bus_write(CMD_HALT, 16'h0, 1'b1);
      bus_write(CMD_OUTREG, 16'h0bad, 1'b1);  // Still in flight when halt lands
      bus_write(CMD_PRINTA, 16'h0bad, 1'b1);
      bus_write(CMD_SENTINEL, 16'h0, 1'b1);   // Written after nhalt has fallen
      drain();
      check_level("nhalt", nhalt, 1'b0);
      check_word("out_reg", out_reg, m_out);
      apply_reset();
      check_level("nhalt", nhalt, 1'b1);
      check_word("out_reg", out_reg, m_out);
      total = val_errs + proto_errs + wait_errs + u_dfp_top.u_props.assert_errs;
      $display("Errors: value %0d, protocol %0d, timeout %0d, assertion %0d",
               val_errs, proto_errs, wait_errs, u_dfp_top.u_props.assert_errs);
      if (total == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
logic/dfp_bus_pkg.sv
logic/dfp_report_pkg.sv
logic/dfp_cmd_if.sv
logic/dfp_bus_capture.sv
logic/dfp_cmd_decode.sv
logic/dfp_exec.sv
logic/dfp_top.sv
tests/dfp_properties.sv
tests/dfp_tb.sv
